//--- source/phy_params.svh
`ifndef PHY_PARAMS_SVH
`define PHY_PARAMS_SVH

// receive core sizes
`define NTI   4   // interleaved adc lanes
`define NADC  8   // magnitude bits per adc word
`define NPI   9   // pi control code width
`define NOUT  4   // pi output phases

// capture window of the dump memory, in clk_adc cycles
`define NDUMP 16

`endif

//--- source/adc_pkg.sv
`include "phy_params.svh"

package adc_pkg;

	// one adc lane word in sign-magnitude form
	typedef struct packed {
		logic             sign;  // 1 for negative
		logic [`NADC-1:0] mag;
	} adc_word_t;

	// one lane after decode
	typedef struct packed {
		logic signed [`NADC:0] value;  // two's complement
		logic                  data;   // sliced bit
	} sample_t;

	// all lanes of one clk_adc cycle, lane 0 is the oldest
	typedef sample_t [`NTI-1:0] sample_vec_t;

endpackage

//--- source/ctrl_pkg.sv
`include "phy_params.svh"

package ctrl_pkg;

	// configuration register map
	typedef enum logic [1:0] {
		CFG_CDR_EN    = 2'd0,  // loop enable in bit 0
		CFG_GAIN      = 2'd1,  // step is 1 << gain
		CFG_PI_LOAD   = 2'd2,  // direct accumulator write
		CFG_PHASE_SEP = 2'd3   // code spacing between output phases
	} cfg_addr_e;

	// loop controls seen by the cdr
	typedef struct packed {
		logic            en;
		logic [2:0]      gain;       // shift of 0 to 7
		logic            load;       // one cycle strobe
		logic [`NPI-1:0] load_val;
		logic [`NPI-1:0] phase_sep;
	} cdr_ctl_t;

	// dump capture fsm
	typedef enum logic [1:0] {
		DUMP_IDLE    = 2'd0,
		DUMP_CAPTURE = 2'd1,
		DUMP_DONE    = 2'd2
	} dump_state_e;

endpackage

//--- source/cfg_regfile.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module cfg_regfile (
	input  logic                clk_adc,
	input  logic                rst_n_i,
	input  logic                cfg_we_i,
	input  ctrl_pkg::cfg_addr_e cfg_addr_i,
	input  logic [`NPI-1:0]     cfg_data_i,
	output ctrl_pkg::cdr_ctl_t  cdr_ctl_o
);
	import ctrl_pkg::*;

	logic            en_q;
	logic [2:0]      gain_q;
	logic            load_q;
	logic [`NPI-1:0] load_val_q;
	logic [`NPI-1:0] sep_q;

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			en_q   <= 1'b0;
			gain_q <= '0;
			load_q <= 1'b0;
			sep_q  <= '0;
		end else begin
			load_q <= 1'b0;  // strobe drops after one cycle
			if (cfg_we_i) begin
				case (cfg_addr_i)
					CFG_CDR_EN:    en_q   <= cfg_data_i[0];
					CFG_GAIN:      gain_q <= cfg_data_i[2:0];
					CFG_PI_LOAD:   load_q <= 1'b1;
					CFG_PHASE_SEP: sep_q  <= cfg_data_i;
					default: ;
				endcase
			end
		end
	end

	// value travels with the load strobe
	always_ff @(posedge clk_adc) begin
		if (cfg_we_i && cfg_addr_i == CFG_PI_LOAD)
			load_val_q <= cfg_data_i;
	end

	assign cdr_ctl_o.en        = en_q;
	assign cdr_ctl_o.gain      = gain_q;
	assign cdr_ctl_o.load      = load_q;
	assign cdr_ctl_o.load_val  = load_val_q;
	assign cdr_ctl_o.phase_sep = sep_q;

endmodule

//--- source/adc_decode.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module adc_decode (
	input  logic                          clk_adc,
	input  logic                          rst_n_i,
	input  adc_pkg::adc_word_t [`NTI-1:0] adc_word_i,
	output adc_pkg::sample_vec_t          samples_o
);
	import adc_pkg::*;

	sample_vec_t samples_d;

	// sign-magnitude to two's complement plus slicer
	function automatic sample_t decode_lane(input adc_word_t w);
		sample_t              s;
		logic signed [`NADC:0] m;
		m = $signed({1'b0, w.mag});
		s.value = w.sign ? -m : m;  // zero magnitude stays 0 either way
		s.data  = ~w.sign;
		return s;
	endfunction

	always_comb begin
		for (int k = 0; k < `NTI; k++) begin
			samples_d[k] = decode_lane(adc_word_i[k]);
		end
	end

	// one register stage for the whole vector
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			samples_o <= '0;
		end else begin
			samples_o <= samples_d;
		end
	end

endmodule

//--- source/cdr_execute.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module cdr_execute (
	input  logic                       clk_adc,
	input  logic                       rst_n_i,
	input  adc_pkg::sample_vec_t       samples_i,
	input  ctrl_pkg::cdr_ctl_t         cdr_ctl_i,
	output logic [`NOUT-1:0][`NPI-1:0] pi_code_o
);
	import adc_pkg::*;

	localparam int TW = `NADC + 2;          // one symbol-times-value product
	localparam int SW = TW + $clog2(`NTI);  // sum over all lanes
	localparam int NP = `NPI;

	sample_t              prev_last;  // lane NTI-1 of the last cycle
	logic signed [SW-1:0] pd_sum;
	logic                 pd_late;
	logic                 pd_early;
	logic [`NPI-1:0]      acc;
	logic [`NPI-1:0]      step;

	// data bit 1 maps to +1, 0 to -1
	function automatic logic signed [TW-1:0] sym_mul(input sample_t sym_s, input sample_t val_s);
		logic signed [TW-1:0] v;
		v = TW'(val_s.value);
		return sym_s.data ? v : -v;
	endfunction

	// mueller-muller term per lane, previous symbol x current minus current symbol x previous
	always_comb begin
		sample_t prev;
		prev   = prev_last;
		pd_sum = '0;
		for (int k = 0; k < `NTI; k++) begin
			pd_sum = pd_sum + SW'(sym_mul(prev, samples_i[k]));
			pd_sum = pd_sum - SW'(sym_mul(samples_i[k], prev));
			prev   = samples_i[k];
		end
	end

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prev_last <= '0;
			pd_late   <= 1'b0;
			pd_early  <= 1'b0;
		end else begin
			prev_last <= samples_i[`NTI-1];
			pd_late   <= pd_sum > 0;  // positive sum pushes the code up
			pd_early  <= pd_sum < 0;
		end
	end

	assign step = NP'(1) << cdr_ctl_i.gain;

	// bang-bang loop filter, wraps modulo 2**NPI
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc <= '0;
		end else if (cdr_ctl_i.load) begin
			acc <= cdr_ctl_i.load_val;  // load wins over a step
		end else if (cdr_ctl_i.en && pd_late) begin
			acc <= acc + step;
		end else if (cdr_ctl_i.en && pd_early) begin
			acc <= acc - step;
		end
	end

	// phase j sits j spacings above the accumulator
	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pi_code_o <= '0;
		end else begin
			for (int j = 0; j < `NOUT; j++) begin
				pi_code_o[j] <= acc + NP'(j) * cdr_ctl_i.phase_sep;
			end
		end
	end

endmodule

//--- source/dump_result.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module dump_result (
	input  logic                      clk_adc,
	input  logic                      rst_n_i,
	input  adc_pkg::sample_vec_t      samples_i,
	input  logic                      dump_start_i,
	input  logic [$clog2(`NDUMP)-1:0] dump_addr_i,
	output logic                      dump_done_o,
	output adc_pkg::sample_vec_t      dump_data_o
);
	import adc_pkg::*;
	import ctrl_pkg::*;

	localparam int AW = $clog2(`NDUMP);

	dump_state_e   state;
	logic [AW-1:0] wr_ptr;
	sample_vec_t   mem [`NDUMP];

	always_ff @(posedge clk_adc or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state  <= DUMP_IDLE;
			wr_ptr <= '0;
		end else if (dump_start_i) begin
			state  <= DUMP_CAPTURE;  // restart from any state
			wr_ptr <= '0;
		end else begin
			case (state)
				DUMP_CAPTURE: begin
					wr_ptr <= wr_ptr + 1'b1;
					if (wr_ptr == AW'(`NDUMP - 1))
						state <= DUMP_DONE;  // last store this edge
				end
				default: ;  // idle and done wait for a start
			endcase
		end
	end

	// sample memory
	always_ff @(posedge clk_adc) begin
		if (state == DUMP_CAPTURE)
			mem[wr_ptr] <= samples_i;
	end

	// readback with one cycle latency
	always_ff @(posedge clk_adc) begin
		dump_data_o <= mem[dump_addr_i];
	end

	assign dump_done_o = (state == DUMP_DONE);

endmodule

//--- source/rx_digital_core.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module rx_digital_core (
	input  logic                          clk_adc,
	input  logic                          rst_n_i,
	input  adc_pkg::adc_word_t [`NTI-1:0] adc_word_i,
	input  logic                          cfg_we_i,
	input  ctrl_pkg::cfg_addr_e           cfg_addr_i,
	input  logic [`NPI-1:0]               cfg_data_i,
	input  logic                          dump_start_i,
	input  logic [$clog2(`NDUMP)-1:0]     dump_addr_i,
	output logic [`NOUT-1:0][`NPI-1:0]    pi_code_o,
	output logic                          dump_done_o,
	output adc_pkg::sample_vec_t          dump_data_o
);
	import adc_pkg::*;
	import ctrl_pkg::*;

	cdr_ctl_t    cdr_ctl;  // loop controls
	sample_vec_t samples;  // decoded lanes, one cycle behind the adc

	// configuration registers
	cfg_regfile cfg_regfile_i (
		.clk_adc    (clk_adc),
		.rst_n_i    (rst_n_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_data_i (cfg_data_i),
		.cdr_ctl_o  (cdr_ctl)
	);

	adc_decode adc_decode_i (
		.clk_adc    (clk_adc),
		.rst_n_i    (rst_n_i),
		.adc_word_i (adc_word_i),
		.samples_o  (samples)
	);

	// phase detector and loop filter
	cdr_execute cdr_execute_i (
		.clk_adc    (clk_adc),
		.rst_n_i    (rst_n_i),
		.samples_i  (samples),
		.cdr_ctl_i  (cdr_ctl),
		.pi_code_o  (pi_code_o)  // to the pi control inputs
	);

	dump_result dump_result_i (
		.clk_adc      (clk_adc),
		.rst_n_i      (rst_n_i),
		.samples_i    (samples),
		.dump_start_i (dump_start_i),
		.dump_addr_i  (dump_addr_i),
		.dump_done_o  (dump_done_o),
		.dump_data_o  (dump_data_o)
	);

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	// free running, starts low
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

//--- dv/tb_rx_digital_core.sv
`timescale 1ns/1ns
`include "phy_params.svh"

module tb_rx_digital_core;
	import adc_pkg::*;
	import ctrl_pkg::*;

	typedef adc_word_t [`NTI-1:0] word_vec_t;

	localparam int CLK_NS = 20;
	localparam int AW     = $clog2(`NDUMP);
	// reset, idle, load, track, const/wrap, two dumps
	localparam int TEST_CYCLES = 3 + 20 + 8 + 65 + 41 + 2 * (3 * `NDUMP + 4);

	logic                       clk_adc;
	logic                       rst_n;
	word_vec_t                  adc_word;
	logic                       cfg_we;
	cfg_addr_e                  cfg_addr;
	logic [`NPI-1:0]            cfg_data;
	logic                       dump_start;
	logic [AW-1:0]              dump_addr;
	logic [`NOUT-1:0][`NPI-1:0] pi_code;
	logic                       dump_done;
	sample_vec_t                dump_data;
	int                         errors;

	// reference model state
	sample_vec_t                m_samples;
	sample_t                    m_prev_last;
	int                         m_sum;  // registered detector sum
	logic [`NPI-1:0]            m_acc;
	logic [`NOUT-1:0][`NPI-1:0] m_pi;
	cdr_ctl_t                   m_ctl;

	tb_clkgen #(.PERIOD_NS(CLK_NS)) clkgen_i (.clk_o(clk_adc));

	rx_digital_core rx_digital_core_i (
		.clk_adc      (clk_adc),
		.rst_n_i      (rst_n),
		.adc_word_i   (adc_word),
		.cfg_we_i     (cfg_we),
		.cfg_addr_i   (cfg_addr),
		.cfg_data_i   (cfg_data),
		.dump_start_i (dump_start),
		.dump_addr_i  (dump_addr),
		.pi_code_o    (pi_code),
		.dump_done_o  (dump_done),
		.dump_data_o  (dump_data)
	);

	function automatic adc_word_t make_word(input logic sign, input int mag);
		adc_word_t w;
		w.sign = sign;
		w.mag  = `NADC'(mag);
		return w;
	endfunction

	// sign-magnitude to signed value with the inverted sign as bit
	function automatic sample_vec_t decode_vec(input word_vec_t w);
		sample_vec_t sv;
		int          v;
		for (int k = 0; k < `NTI; k++) begin
			v = w[k].sign ? -int'(w[k].mag) : int'(w[k].mag);
			sv[k].value = (`NADC+1)'(v);
			sv[k].data  = !w[k].sign;
		end
		return sv;
	endfunction

	// mueller-muller sum over symbols of +1 or -1
	function automatic int mm_sum(input sample_t last, input sample_vec_t cur);
		int      sum;
		int      sym_p;
		int      sym_c;
		sample_t p;
		sum = 0;
		p   = last;
		for (int k = 0; k < `NTI; k++) begin
			sym_p = p.data ? 1 : -1;
			sym_c = cur[k].data ? 1 : -1;
			sum   += sym_p * int'($signed(cur[k].value)) - sym_c * int'($signed(p.value));
			p     = cur[k];
		end
		return sum;
	endfunction

	function automatic word_vec_t rand_words();
		word_vec_t w;
		for (int k = 0; k < `NTI; k++) begin
			w[k] = make_word(1'($urandom), int'($urandom_range(0, 255)));
			if ($urandom_range(0, 5) == 0)
				w[k].mag = '0;  // both zero codes show up
		end
		return w;
	endfunction

	// cycle model reading old values before the updates below them
	always @(posedge clk_adc or negedge rst_n) begin
		if (!rst_n) begin
			m_samples   = '0;
			m_prev_last = '0;
			m_sum       = 0;
			m_acc       = '0;
			m_pi        = '0;
			m_ctl       = '0;
		end else begin
			for (int j = 0; j < `NOUT; j++)
				m_pi[j] = m_acc + `NPI'(j) * m_ctl.phase_sep;
			if (m_ctl.load)
				m_acc = m_ctl.load_val;
			else if (m_ctl.en && m_sum > 0)
				m_acc = m_acc + (`NPI'(1) << m_ctl.gain);
			else if (m_ctl.en && m_sum < 0)
				m_acc = m_acc - (`NPI'(1) << m_ctl.gain);
			m_sum       = mm_sum(m_prev_last, m_samples);
			m_prev_last = m_samples[`NTI-1];
			m_samples   = decode_vec(adc_word);
			m_ctl.load  = cfg_we && cfg_addr == CFG_PI_LOAD;
			if (cfg_we) begin
				case (cfg_addr)
					CFG_CDR_EN:    m_ctl.en        = cfg_data[0];
					CFG_GAIN:      m_ctl.gain      = cfg_data[2:0];
					CFG_PI_LOAD:   m_ctl.load_val  = cfg_data;
					CFG_PHASE_SEP: m_ctl.phase_sep = cfg_data;
					default: ;
				endcase
			end
		end
	end

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_pi(input string tag);
		for (int j = 0; j < `NOUT; j++) begin
			if (pi_code[j] !== m_pi[j])
				report_mismatch($sformatf("%s phase %0d got %0d expected %0d",
					tag, j, pi_code[j], m_pi[j]));
		end
	endtask

	task automatic cfg_write(input cfg_addr_e addr, input int data);
		@(posedge clk_adc);
		cfg_we   <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= `NPI'(data);
		@(posedge clk_adc);
		cfg_we   <= 1'b0;
	endtask

	task automatic drive_traffic(input int n, input bit expect_zero);
		repeat (n) begin
			@(posedge clk_adc);
			adc_word <= rand_words();
			@(negedge clk_adc);
			if (expect_zero && pi_code !== '0)
				report_mismatch($sformatf("pi_code_o %h not zero, loop disabled", pi_code));
			check_pi("traffic");
		end
	endtask

	task automatic load_and_space();
		int ld;
		int sep;
		ld  = $urandom_range(0, 511);
		sep = $urandom_range(0, 511);
		cfg_write(CFG_PHASE_SEP, sep);
		cfg_write(CFG_PI_LOAD, ld);
		drive_traffic(4, 1'b0);
		for (int j = 0; j < `NOUT; j++) begin
			if (int'(pi_code[j]) != (ld + j * sep) % (1 << `NPI))
				report_mismatch($sformatf("phase %0d is %0d after load %0d sep %0d",
					j, pi_code[j], ld, sep));
		end
	endtask

	task automatic track_random_words();
		int              gain;
		logic [`NPI-1:0] step;
		logic [`NPI-1:0] last;
		logic [`NPI-1:0] diff;
		gain = $urandom_range(1, 4);
		step = `NPI'(1) << gain;
		cfg_write(CFG_GAIN, gain);
		cfg_write(CFG_CDR_EN, 1);
		@(negedge clk_adc);
		last = pi_code[0];
		repeat (60) begin
			@(posedge clk_adc);
			adc_word <= rand_words();
			@(negedge clk_adc);
			check_pi("track");
			diff = pi_code[0] - last;
			if (diff != 0 && diff != step && diff != -step)
				report_mismatch($sformatf("code moved by %0d, step %0d", diff, step));
			last = pi_code[0];
		end
	endtask

	task automatic hold_and_wrap();
		word_vec_t       w;
		logic [`NPI-1:0] held;
		for (int k = 0; k < `NTI; k++)
			w[k] = make_word(1'b0, 37);
		@(posedge clk_adc);
		adc_word <= w;
		repeat (6) @(negedge clk_adc);  // pipeline settles
		held = pi_code[0];
		repeat (10) begin
			@(negedge clk_adc);
			check_pi("const");
			if (pi_code[0] !== held)
				report_mismatch($sformatf("code moved from %0d on constant words", held));
		end
		// +1 +50 -1 -50 gives a positive sum every cycle
		w[0] = make_word(1'b0, 1);
		w[1] = make_word(1'b0, 50);
		w[2] = make_word(1'b1, 1);
		w[3] = make_word(1'b1, 50);
		cfg_write(CFG_GAIN, 3);
		cfg_write(CFG_PI_LOAD, 500);
		@(posedge clk_adc);
		adc_word <= w;
		repeat (20) begin
			@(negedge clk_adc);
			check_pi("wrap");
		end
		if (pi_code[0] >= `NPI'(500))
			report_mismatch($sformatf("code %0d did not wrap past 511", pi_code[0]));
	endtask

	task automatic capture_window(input bit done_before);
		sample_vec_t exp_win [`NDUMP];
		word_vec_t   w;
		int          waited;
		@(negedge clk_adc);
		if (dump_done !== done_before)
			report_mismatch($sformatf("dump_done_o %b before the pulse", dump_done));
		for (int i = 0; i < `NDUMP; i++) begin
			@(posedge clk_adc);
			w = rand_words();
			adc_word   <= w;
			dump_start <= (i == 0);
			exp_win[i] = decode_vec(w);  // words sent with and after the pulse
			if (i == 1) begin
				@(negedge clk_adc);
				if (dump_done !== 1'b0)
					report_mismatch("dump_done_o high after a dump start");
			end
		end
		waited = 0;
		while (dump_done !== 1'b1 && waited < 2 * `NDUMP) begin
			@(posedge clk_adc);
			adc_word <= rand_words();
			@(negedge clk_adc);
			waited++;
		end
		if (dump_done !== 1'b1) begin
			$display("dump_done_o did not rise within %0d cycles", 2 * `NDUMP);
			errors++;
		end
		for (int a = 0; a < `NDUMP; a++) begin
			@(posedge clk_adc);
			dump_addr <= AW'(a);
			@(negedge clk_adc);
			// output register still holds the previous address
			if (a > 0 && dump_data !== exp_win[a-1])
				report_mismatch($sformatf("dump word %0d showed before its read latency",
					a));
			@(negedge clk_adc);
			if (dump_data !== exp_win[a])
				report_mismatch($sformatf("dump word %0d got %h expected %h",
					a, dump_data, exp_win[a]));
		end
	endtask

	initial begin
		#(2 * TEST_CYCLES * CLK_NS);
		$display("timeout, tests still running after %0d ns", 2 * TEST_CYCLES * CLK_NS);
		$display("errors: %0d", errors);
		$display("Verification failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h0c0fe536));
		errors     = 0;
		rst_n      = 1'b0;
		adc_word   = '0;
		cfg_we     = 1'b0;
		cfg_addr   = CFG_CDR_EN;
		cfg_data   = '0;
		dump_start = 1'b0;
		dump_addr  = '0;
		repeat (3) @(posedge clk_adc);
		rst_n <= 1'b1;
		drive_traffic(20, 1'b1);  // loop still disabled
		load_and_space();
		track_random_words();
		hold_and_wrap();
		capture_window(1'b0);
		capture_window(1'b1);  // second window clears done first
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+source
source/adc_pkg.sv
source/ctrl_pkg.sv
source/cfg_regfile.sv
source/adc_decode.sv
source/cdr_execute.sv
source/dump_result.sv
source/rx_digital_core.sv
dv/tb_clkgen.sv
dv/tb_rx_digital_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench with verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_rx_digital_core \
	-Mdir obj_dir > sim.log 2>&1 \
	&& ./obj_dir/Vtb_rx_digital_core >> sim.log 2>&1 \
	|| { echo "build or run error, see sim.log"; exit 1; }

grep -q "Verification failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
